/* exec_core.f */
+incdir+logic
logic/rv_isa_pkg.sv
logic/ex_pipe_pkg.sv
logic/rv_alu.sv
logic/pc_unit.sv
logic/ex_stage.sv
logic/exec_core.sv
test/exec_core_tb.sv

/* logic/ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Datapath widths
`define EX_DWIDTH        32
`define EX_AWIDTH        5
`define EX_PCWIDTH       32
`define EX_FUNCT_WIDTH   3

// One-hot vector widths
`define EX_ALU_WIDTH     14
`define EX_OPCODE_WIDTH  11

// ALU operation bits
`define EX_ADD           0
`define EX_SUB           1
`define EX_SLT           2
`define EX_SLTU          3
`define EX_XOR           4
`define EX_OR            5
`define EX_AND           6
`define EX_SLL           7
`define EX_SRL           8
`define EX_SRA           9
`define EX_EQ            10
`define EX_NEQ           11
`define EX_GE            12
`define EX_GEU           13

// Opcode class bits
`define EX_RTYPE         0
`define EX_ITYPE         1
`define EX_LOAD          2
`define EX_STORE         3
`define EX_BRANCH        4
`define EX_JAL           5
`define EX_JALR          6
`define EX_LUI           7
`define EX_AUIPC         8
`define EX_SYSTEM        9
`define EX_FENCE         10

`endif

/* logic/ex_pipe_pkg.sv */
package ex_pipe_pkg;

    // Decoded instruction entering execute
    typedef struct packed {
        rv_isa_pkg::alu_op_t   alu;
        rv_isa_pkg::opcode_t   opcode;
        rv_isa_pkg::funct3_t   funct3;
        rv_isa_pkg::reg_addr_t addr_rs1;
        rv_isa_pkg::reg_addr_t addr_rs2;
        rv_isa_pkg::reg_addr_t addr_rd;
        rv_isa_pkg::word_t     data_rs1;
        rv_isa_pkg::word_t     data_rs2;
        rv_isa_pkg::word_t     imm;
        rv_isa_pkg::pc_t       pc;
    } ex_in_t;

    // Source operands after the bypass
    typedef struct packed {
        rv_isa_pkg::word_t rs1;
        rv_isa_pkg::word_t rs2;
    } operand_t;

    typedef struct packed {
        rv_isa_pkg::word_t value;
    } alu_res_t;

    // Control-flow decision and its write-back value
    typedef struct packed {
        rv_isa_pkg::pc_t   next_pc;
        logic              redirect;
        logic              writes_rd;
        rv_isa_pkg::word_t rd_value;
    } flow_res_t;

    // Registered stage output
    typedef struct packed {
        rv_isa_pkg::word_t     alu_value;
        rv_isa_pkg::word_t     data_rd;
        rv_isa_pkg::reg_addr_t addr_rd;
        logic                  we_reg;
        logic                  valid;
        rv_isa_pkg::pc_t       next_pc;
        logic                  change_pc;
        logic                  flush;
        logic                  ce;
        // Carried on for the memory stage
        rv_isa_pkg::alu_op_t   alu;
        rv_isa_pkg::opcode_t   opcode;
        rv_isa_pkg::funct3_t   funct3;
        rv_isa_pkg::reg_addr_t addr_rs1;
        rv_isa_pkg::reg_addr_t addr_rs2;
        rv_isa_pkg::word_t     data_rs1;
        rv_isa_pkg::word_t     data_rs2;
        rv_isa_pkg::word_t     imm;
        rv_isa_pkg::pc_t       pc;
    } ex_out_t;

endpackage

/* logic/ex_stage.sv */
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_stage (
    input  logic                    ex_clk,
    input  logic                    ex_rst,
    input  ex_pipe_pkg::ex_in_t     ex_in,
    input  logic                    ce,
    input  logic                    stall,
    input  logic                    flush,
    input  ex_pipe_pkg::alu_res_t   alu_res,
    input  ex_pipe_pkg::flow_res_t  flow_res,
    output ex_pipe_pkg::operand_t   fwd,
    output ex_pipe_pkg::ex_out_t    ex_out
);

    logic accept;
    logic alu_writes;
    logic hit_rs1;
    logic hit_rs2;

    assign accept     = ce & ~stall & ~flush;
    assign alu_writes = ex_in.opcode[`EX_RTYPE] | ex_in.opcode[`EX_ITYPE];

    // Bypass of the result written last cycle
    assign hit_rs1 = ex_out.we_reg && (ex_out.addr_rd == ex_in.addr_rs1);
    assign hit_rs2 = ex_out.we_reg && (ex_out.addr_rd == ex_in.addr_rs2);

    assign fwd.rs1 = hit_rs1 ? ex_out.data_rd : ex_in.data_rs1;
    assign fwd.rs2 = hit_rs2 ? ex_out.data_rd : ex_in.data_rs2;

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            ex_out <= '0;
        end else begin
            // Pulses drop unless set again below
            ex_out.we_reg    <= 1'b0;
            ex_out.valid     <= 1'b0;
            ex_out.change_pc <= 1'b0;
            ex_out.flush     <= 1'b0;
            ex_out.ce        <= 1'b0;
            ex_out.alu       <= '0;
            ex_out.opcode    <= '0;
            ex_out.funct3    <= '0;
            ex_out.data_rd   <= '0;

            if (accept) begin
                ex_out.ce        <= 1'b1;
                ex_out.alu       <= ex_in.alu;
                ex_out.opcode    <= ex_in.opcode;
                ex_out.funct3    <= ex_in.funct3;
                ex_out.addr_rs1  <= ex_in.addr_rs1;
                ex_out.addr_rs2  <= ex_in.addr_rs2;
                ex_out.data_rs1  <= ex_in.data_rs1;
                ex_out.data_rs2  <= ex_in.data_rs2;
                ex_out.imm       <= ex_in.imm;
                ex_out.pc        <= ex_in.pc;
                ex_out.addr_rd   <= ex_in.addr_rd;
                ex_out.alu_value <= alu_res.value;
                ex_out.next_pc   <= flow_res.next_pc;
                ex_out.change_pc <= flow_res.redirect;
                ex_out.flush     <= flow_res.redirect;

                if (alu_writes) begin
                    ex_out.data_rd <= alu_res.value;
                    ex_out.we_reg  <= 1'b1;
                    ex_out.valid   <= 1'b1;
                end else if (flow_res.writes_rd) begin
                    // jal, jalr, lui, auipc
                    ex_out.data_rd <= flow_res.rd_value;
                    ex_out.we_reg  <= 1'b1;
                    ex_out.valid   <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/exec_core.sv */
`timescale 1ns/1ps

module exec_core (
    input  logic                  ex_clk,
    input  logic                  ex_rst,
    input  ex_pipe_pkg::ex_in_t   ex_in,
    input  logic                  ce,
    input  logic                  stall,
    input  logic                  flush,
    output ex_pipe_pkg::ex_out_t  ex_out
);

    ex_pipe_pkg::operand_t  fwd;
    ex_pipe_pkg::alu_res_t  alu_res;
    ex_pipe_pkg::flow_res_t flow_res;

    ex_stage u_stage (
        .ex_clk   (ex_clk),
        .ex_rst   (ex_rst),
        .ex_in    (ex_in),
        .ce       (ce),
        .stall    (stall),
        .flush    (flush),
        .alu_res  (alu_res),
        .flow_res (flow_res),
        .fwd      (fwd),
        .ex_out   (ex_out)
    );

    // Both units see the same bypassed operands
    rv_alu u_alu (
        .ex_in   (ex_in),
        .fwd     (fwd),
        .alu_res (alu_res)
    );

    pc_unit u_pc (
        .ex_in    (ex_in),
        .fwd      (fwd),
        .alu_res  (alu_res),
        .flow_res (flow_res)
    );

endmodule

/* logic/pc_unit.sv */
`timescale 1ns/1ps
`include "ex_defs.svh"

module pc_unit (
    input  ex_pipe_pkg::ex_in_t      ex_in,
    input  ex_pipe_pkg::operand_t    fwd,
    input  ex_pipe_pkg::alu_res_t    alu_res,
    output ex_pipe_pkg::flow_res_t   flow_res
);

    localparam rv_isa_pkg::pc_t pc_step = 4;

    rv_isa_pkg::pc_t   pc_plus_imm;
    rv_isa_pkg::pc_t   pc_plus_4;
    rv_isa_pkg::word_t jalr_sum;

    assign pc_plus_imm = ex_in.pc + ex_in.imm;
    assign pc_plus_4   = ex_in.pc + pc_step;
    assign jalr_sum    = fwd.rs1 + ex_in.imm;

    always_comb begin
        flow_res.next_pc   = ex_in.pc;
        flow_res.redirect  = 1'b0;
        flow_res.writes_rd = 1'b0;
        flow_res.rd_value  = '0;

        if (ex_in.opcode[`EX_BRANCH]) begin
            // Compare result from the ALU
            if (alu_res.value[0]) begin
                flow_res.next_pc  = pc_plus_imm;
                flow_res.redirect = 1'b1;
            end else begin
                flow_res.next_pc = pc_plus_4;
            end
        end else if (ex_in.opcode[`EX_JAL]) begin
            flow_res.next_pc   = pc_plus_imm;
            flow_res.redirect  = 1'b1;
            flow_res.writes_rd = 1'b1;
            flow_res.rd_value  = pc_plus_4;
        end else if (ex_in.opcode[`EX_JALR]) begin
            flow_res.next_pc   = {jalr_sum[`EX_PCWIDTH-1:1], 1'b0};
            flow_res.redirect  = 1'b1;
            flow_res.writes_rd = 1'b1;
            flow_res.rd_value  = pc_plus_4;
        end else if (ex_in.opcode[`EX_LUI]) begin
            flow_res.writes_rd = 1'b1;
            flow_res.rd_value  = {ex_in.imm[`EX_DWIDTH-1:12], 12'b0};
        end else if (ex_in.opcode[`EX_AUIPC]) begin
            flow_res.writes_rd = 1'b1;
            flow_res.rd_value  = pc_plus_imm;
        end
    end

endmodule

/* logic/rv_alu.sv */
`timescale 1ns/1ps
`include "ex_defs.svh"

module rv_alu (
    input  ex_pipe_pkg::ex_in_t     ex_in,
    input  ex_pipe_pkg::operand_t   fwd,
    output ex_pipe_pkg::alu_res_t   alu_res
);

    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    logic [4:0]        shamt;
    logic              use_pc;
    logic              use_rs2;

    assign use_pc  = ex_in.opcode[`EX_JAL] | ex_in.opcode[`EX_AUIPC];
    assign use_rs2 = ex_in.opcode[`EX_RTYPE] | ex_in.opcode[`EX_BRANCH];

    // Operand select
    always_comb begin
        if (use_pc) begin
            a = ex_in.pc;
        end else if (ex_in.opcode[`EX_LUI]) begin
            a = '0;
        end else begin
            a = fwd.rs1;
        end
        b = use_rs2 ? fwd.rs2 : ex_in.imm;
    end

    assign shamt = b[4:0];

    // One-hot select, nothing set gives zero
    always_comb begin
        alu_res.value = '0;
        if (ex_in.alu[`EX_ADD]) begin
            alu_res.value = a + b;
        end else if (ex_in.alu[`EX_SUB]) begin
            alu_res.value = a - b;
        end else if (ex_in.alu[`EX_SLT]) begin
            alu_res.value[0] = $signed(a) < $signed(b);
        end else if (ex_in.alu[`EX_SLTU]) begin
            alu_res.value[0] = a < b;
        end else if (ex_in.alu[`EX_XOR]) begin
            alu_res.value = a ^ b;
        end else if (ex_in.alu[`EX_OR]) begin
            alu_res.value = a | b;
        end else if (ex_in.alu[`EX_AND]) begin
            alu_res.value = a & b;
        end else if (ex_in.alu[`EX_SLL]) begin
            alu_res.value = a << shamt;
        end else if (ex_in.alu[`EX_SRL]) begin
            alu_res.value = a >> shamt;
        end else if (ex_in.alu[`EX_SRA]) begin
            alu_res.value = $signed(a) >>> shamt;
        end else if (ex_in.alu[`EX_EQ]) begin
            // Branch compares leave their outcome in bit 0
            alu_res.value[0] = (a == b);
        end else if (ex_in.alu[`EX_NEQ]) begin
            alu_res.value[0] = (a != b);
        end else if (ex_in.alu[`EX_GE]) begin
            alu_res.value[0] = $signed(a) >= $signed(b);
        end else if (ex_in.alu[`EX_GEU]) begin
            alu_res.value[0] = a >= b;
        end
    end

endmodule

/* logic/rv_isa_pkg.sv */
`include "ex_defs.svh"

package rv_isa_pkg;

    // Register file contents and immediates
    typedef logic [`EX_DWIDTH-1:0] word_t;

    // Register numbers x0..x31
    typedef logic [`EX_AWIDTH-1:0] reg_addr_t;

    // Instruction address
    typedef logic [`EX_PCWIDTH-1:0] pc_t;

    // Sub-operation field from the instruction word
    typedef logic [`EX_FUNCT_WIDTH-1:0] funct3_t;

    // One bit per ALU operation, at most one set
    typedef logic [`EX_ALU_WIDTH-1:0] alu_op_t;

    // One bit per major opcode class
    typedef logic [`EX_OPCODE_WIDTH-1:0] opcode_t;

endpackage

/* test/exec_core_tb.sv */
`timescale 1ns/1ps
`include "ex_defs.svh"

module exec_core_tb;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    localparam int num_rows     = 25;

    typedef struct packed {
        ex_pipe_pkg::ex_in_t ins;
        logic                ce;
        logic                stall;
        logic                flush;
    } row_t;

    logic                 ex_clk;
    logic                 ex_rst;
    ex_pipe_pkg::ex_in_t  ex_in;
    logic                 ce;
    logic                 stall;
    logic                 flush;
    ex_pipe_pkg::ex_out_t ex_out;

    row_t                 rows [num_rows];
    int                   row_count;
    integer               seed;
    ex_pipe_pkg::ex_out_t expected;

    exec_core uut (
        .ex_clk (ex_clk),
        .ex_rst (ex_rst),
        .ex_in  (ex_in),
        .ce     (ce),
        .stall  (stall),
        .flush  (flush),
        .ex_out (ex_out)
    );

    initial begin
        ex_clk = 1'b0;
        forever #(clk_period / 2) ex_clk = ~ex_clk;
    end

    // Watchdog
    initial begin
        #((num_rows + reset_cycles + 10) * clk_period);
        $display("Timeout: the test did not complete within the expected number of cycles");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs(input ex_pipe_pkg::ex_out_t exp);
        check_value("alu_value", ex_out.alu_value, exp.alu_value);
        check_value("data_rd", ex_out.data_rd, exp.data_rd);
        check_value("addr_rd", ex_out.addr_rd, exp.addr_rd);
        check_value("we_reg", ex_out.we_reg, exp.we_reg);
        check_value("valid", ex_out.valid, exp.valid);
        check_value("next_pc", ex_out.next_pc, exp.next_pc);
        check_value("change_pc", ex_out.change_pc, exp.change_pc);
        check_value("flush", ex_out.flush, exp.flush);
        check_value("ce", ex_out.ce, exp.ce);
        check_value("alu", ex_out.alu, exp.alu);
        check_value("opcode", ex_out.opcode, exp.opcode);
        check_value("funct3", ex_out.funct3, exp.funct3);
        check_value("addr_rs1", ex_out.addr_rs1, exp.addr_rs1);
        check_value("addr_rs2", ex_out.addr_rs2, exp.addr_rs2);
        check_value("data_rs1", ex_out.data_rs1, exp.data_rs1);
        check_value("data_rs2", ex_out.data_rs2, exp.data_rs2);
        check_value("imm", ex_out.imm, exp.imm);
        check_value("pc", ex_out.pc, exp.pc);
    endtask

    // R-type and I-type rows get random register data
    task automatic add_row(input int alu_bit, input int opc_bit, input int rs1, input int rs2,
                           input int rd, input logic [31:0] imm, input logic [31:0] d1,
                           input logic [31:0] d2, input logic [2:0] ctl);
        row_t r;
        r = '0;
        r.ins.alu      = 1 << alu_bit;
        r.ins.opcode   = 1 << opc_bit;
        r.ins.funct3   = row_count[2:0];
        r.ins.addr_rs1 = rs1;
        r.ins.addr_rs2 = rs2;
        r.ins.addr_rd  = rd;
        r.ins.imm      = imm;
        r.ins.pc       = 32'h100 + 4 * row_count;
        r.ins.data_rs1 = d1;
        r.ins.data_rs2 = d2;
        if (opc_bit == `EX_RTYPE || opc_bit == `EX_ITYPE) begin
            r.ins.data_rs1 = $random(seed);
            r.ins.data_rs2 = $random(seed);
        end
        {r.ce, r.stall, r.flush} = ctl;
        rows[row_count] = r;
        row_count++;
    endtask

    function automatic logic [31:0] alu_ref(input logic [13:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (1'b1)
            op[`EX_ADD]:  return a + b;
            op[`EX_SUB]:  return a - b;
            op[`EX_SLT]:  return ($signed(a) < $signed(b)) ? 1 : 0;
            op[`EX_SLTU]: return (a < b) ? 1 : 0;
            op[`EX_XOR]:  return a ^ b;
            op[`EX_OR]:   return a | b;
            op[`EX_AND]:  return a & b;
            op[`EX_SLL]:  return a << b[4:0];
            op[`EX_SRL]:  return a >> b[4:0];
            op[`EX_SRA]:  return $signed(a) >>> b[4:0];
            op[`EX_EQ]:   return (a == b) ? 1 : 0;
            op[`EX_NEQ]:  return (a != b) ? 1 : 0;
            op[`EX_GE]:   return ($signed(a) >= $signed(b)) ? 1 : 0;
            op[`EX_GEU]:  return (a >= b) ? 1 : 0;
            default:      return 32'h0;
        endcase
    endfunction

    // Next expected output from one row and the previous expected output
    function automatic ex_pipe_pkg::ex_out_t model_step(input row_t r,
                                                       input ex_pipe_pkg::ex_out_t prev);
        ex_pipe_pkg::ex_out_t nxt;
        logic [31:0]          r1;
        logic [31:0]          r2;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          res;
        nxt = prev;
        {nxt.we_reg, nxt.valid, nxt.change_pc, nxt.flush, nxt.ce} = '0;
        {nxt.alu, nxt.opcode, nxt.funct3, nxt.data_rd} = '0;
        if (r.ce && !r.stall && !r.flush) begin
            r1 = (prev.we_reg && prev.addr_rd == r.ins.addr_rs1) ? prev.data_rd : r.ins.data_rs1;
            r2 = (prev.we_reg && prev.addr_rd == r.ins.addr_rs2) ? prev.data_rd : r.ins.data_rs2;
            a = r1;
            if (r.ins.opcode[`EX_JAL] || r.ins.opcode[`EX_AUIPC]) a = r.ins.pc;
            else if (r.ins.opcode[`EX_LUI]) a = 32'h0;
            b = (r.ins.opcode[`EX_RTYPE] || r.ins.opcode[`EX_BRANCH]) ? r2 : r.ins.imm;
            res = alu_ref(r.ins.alu, a, b);
            nxt.next_pc = r.ins.pc;
            case (1'b1)
                r.ins.opcode[`EX_BRANCH]: begin
                    nxt.change_pc = res[0];
                    nxt.next_pc   = res[0] ? r.ins.pc + r.ins.imm : r.ins.pc + 4;
                end
                r.ins.opcode[`EX_JAL], r.ins.opcode[`EX_JALR]: begin
                    nxt.change_pc = 1'b1;
                    nxt.we_reg    = 1'b1;
                    nxt.data_rd   = r.ins.pc + 4;
                    nxt.next_pc   = r.ins.opcode[`EX_JAL] ? r.ins.pc + r.ins.imm
                                                          : (r1 + r.ins.imm) & ~32'h1;
                end
                r.ins.opcode[`EX_LUI]: {nxt.we_reg, nxt.data_rd} = {1'b1, r.ins.imm & 32'hfffff000};
                r.ins.opcode[`EX_AUIPC]: {nxt.we_reg, nxt.data_rd} = {1'b1, r.ins.pc + r.ins.imm};
                r.ins.opcode[`EX_RTYPE], r.ins.opcode[`EX_ITYPE]: begin
                    nxt.we_reg  = 1'b1;
                    nxt.data_rd = res;
                end
                default: ;
            endcase
            nxt.valid     = nxt.we_reg;
            nxt.flush     = nxt.change_pc;
            nxt.ce        = 1'b1;
            nxt.alu_value = res;
            nxt.addr_rd   = r.ins.addr_rd;
            {nxt.alu, nxt.opcode, nxt.funct3} = {r.ins.alu, r.ins.opcode, r.ins.funct3};
            {nxt.addr_rs1, nxt.addr_rs2} = {r.ins.addr_rs1, r.ins.addr_rs2};
            {nxt.data_rs1, nxt.data_rs2} = {r.ins.data_rs1, r.ins.data_rs2};
            {nxt.imm, nxt.pc} = {r.ins.imm, r.ins.pc};
        end
        return nxt;
    endfunction

    initial begin
        seed      = 69821;
        row_count = 0;
        ex_rst    = 1'b0;
        ex_in     = '0;
        ce        = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        expected  = '0;

        // ALU operations, several rows forward from the row before
        add_row(`EX_ADD,  `EX_RTYPE,   1,  2,  3, 32'h0,        0, 0, 3'b100);
        add_row(`EX_SUB,  `EX_RTYPE,   3,  4,  5, 32'h0,        0, 0, 3'b100);
        add_row(`EX_SLT,  `EX_RTYPE,   6,  5,  6, 32'h0,        0, 0, 3'b100);
        add_row(`EX_SLTU, `EX_RTYPE,   7,  8,  9, 32'h0,        0, 0, 3'b100);
        add_row(`EX_XOR,  `EX_ITYPE,   9,  0, 10, 32'hfffff0f0, 0, 0, 3'b100);
        add_row(`EX_OR,   `EX_RTYPE,  11, 12, 13, 32'h0,        0, 0, 3'b100);
        add_row(`EX_AND,  `EX_ITYPE,  13,  0, 14, 32'h00000ff3, 0, 0, 3'b100);
        add_row(`EX_SLL,  `EX_RTYPE,  14, 15, 16, 32'h0,        0, 0, 3'b100);
        add_row(`EX_SRL,  `EX_ITYPE,  16,  0, 17, 32'h7,        0, 0, 3'b100);
        add_row(`EX_SRA,  `EX_RTYPE,  20, 17, 19, 32'h0,        0, 0, 3'b100);
        add_row(`EX_EQ,   `EX_RTYPE,  19, 19, 20, 32'h0,        0, 0, 3'b100);
        add_row(`EX_NEQ,  `EX_RTYPE,  21, 22, 21, 32'h0,        0, 0, 3'b100);
        add_row(`EX_GE,   `EX_RTYPE,  21, 23, 22, 32'h0,        0, 0, 3'b100);
        add_row(`EX_GEU,  `EX_ITYPE,  22,  0, 23, 32'h80000000, 0, 0, 3'b100);
        // Control flow
        add_row(`EX_EQ,   `EX_BRANCH, 10, 11,  0, 32'h20, 32'h55, 32'h55, 3'b100);
        add_row(`EX_NEQ,  `EX_BRANCH, 10, 11,  0, 32'h30, 32'h7,  32'h7,  3'b100);
        add_row(`EX_ADD,  `EX_JAL,     0,  0, 12, 32'h40,       0, 0, 3'b100);
        add_row(`EX_ADD,  `EX_JALR,   12,  0, 13, 32'h11,       0, 0, 3'b100);
        add_row(`EX_ADD,  `EX_LUI,     0,  0, 14, 32'h12345abc, 0, 0, 3'b100);
        add_row(`EX_ADD,  `EX_AUIPC,   0,  0, 15, 32'h00001000, 0, 0, 3'b100);
        // Stall, load bubble, flush, ce low, then a normal row
        add_row(`EX_ADD,  `EX_RTYPE,  15,  1, 16, 32'h0,        0, 0, 3'b110);
        add_row(`EX_ADD,  `EX_LOAD,   15,  0, 17, 32'h8, 32'h1000, 0, 3'b100);
        add_row(`EX_ADD,  `EX_ITYPE,   2,  0, 18, 32'h5,        0, 0, 3'b101);
        add_row(`EX_ADD,  `EX_RTYPE,   3,  4, 19, 32'h0,        0, 0, 3'b000);
        add_row(`EX_XOR,  `EX_RTYPE,   5,  6, 20, 32'h0,        0, 0, 3'b100);

        repeat (reset_cycles) @(posedge ex_clk);
        ex_rst <= 1'b1;
        @(negedge ex_clk);
        check_outputs(expected);

        // Each row's result is checked at the falling edge after it is captured
        for (int i = 0; i <= num_rows; i++) begin
            @(posedge ex_clk);
            if (i < num_rows) begin
                ex_in <= rows[i].ins;
                ce    <= rows[i].ce;
                stall <= rows[i].stall;
                flush <= rows[i].flush;
            end else begin
                ce    <= 1'b0;
                stall <= 1'b0;
                flush <= 1'b0;
            end
            @(negedge ex_clk);
            if (i > 0) begin
                expected = model_step(rows[i-1], expected);
                check_outputs(expected);
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule
